// ==== logic/core_pkg.sv ====
package core_pkg;

    // Instruction and address widths
    parameter int WORD_SIZE = 32;
    parameter int ADDR_SIZE = 32;

    // Bytes per instruction word
    parameter int WORD_BYTES = WORD_SIZE / 8;

    // addi x0, x0, 0
    parameter logic [WORD_SIZE-1:0] NOP_INSTR = 32'h0000_0013;

    // Multicycle stages, in execution order
    typedef enum logic [1:0] {
        IF_STAGE = 2'd0,
        ID_STAGE = 2'd1,
        EX_STAGE = 2'd2,
        WB_STAGE = 2'd3
    } stage_e;

    typedef logic [WORD_SIZE-1:0] word_t;
    typedef logic [ADDR_SIZE-1:0] addr_t;

endpackage : core_pkg

// ==== logic/cache_pkg.sv ====
package cache_pkg;

    // Line geometry
    parameter int LINE_BYTES = 16;
    parameter int OFFSET_W = $clog2(LINE_BYTES);
    parameter int WORDS_PER_LINE = LINE_BYTES / core_pkg::WORD_BYTES;
    parameter int WORD_SEL_W = $clog2(WORDS_PER_LINE);

    // One cache line, byte 0 in the low bits
    typedef logic [LINE_BYTES-1:0][7:0] line_t;

    // Line read request towards memory
    typedef struct packed {
        logic                           rd;
        logic [core_pkg::ADDR_SIZE-1:0] line_addr;
    } mem_req_t;

endpackage : cache_pkg

// ==== logic/stage_ctrl.sv ====
`timescale 1ns/1ps

module stage_ctrl (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             hit_i,
    output core_pkg::stage_e stage_o
);

    core_pkg::stage_e stage_q;
    core_pkg::stage_e stage_d;

    // Hold IF until the cache hits, then one cycle per stage
    always_comb begin
        stage_d = stage_q;
        case (stage_q)
            core_pkg::IF_STAGE: begin
                if (hit_i) begin
                    stage_d = core_pkg::ID_STAGE;
                end
            end
            core_pkg::ID_STAGE: begin
                stage_d = core_pkg::EX_STAGE;
            end
            core_pkg::EX_STAGE: begin
                stage_d = core_pkg::WB_STAGE;
            end
            core_pkg::WB_STAGE: begin
                stage_d = core_pkg::IF_STAGE;
            end
            default: begin
                stage_d = core_pkg::IF_STAGE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stage_q <= core_pkg::IF_STAGE;
        end else begin
            stage_q <= stage_d;
        end
    end

    assign stage_o = stage_q;

endmodule : stage_ctrl

// ==== logic/if_stage.sv ====
`timescale 1ns/1ps

module if_stage (
    input  logic                           clk_i,
    input  logic                           rst_n_i,

    // Controller
    input  core_pkg::stage_e               stage_i,

    // Cache
    input  logic                           hit_i,
    input  logic [core_pkg::WORD_SIZE-1:0] word_i,
    output logic                           lookup_o,
    output logic [core_pkg::ADDR_SIZE-1:0] fetch_pc_o,

    // Branch outcome from WB
    input  logic                           tkbr_i,
    input  logic [core_pkg::ADDR_SIZE-1:0] new_pc_i,

    // To decode
    output logic [core_pkg::WORD_SIZE-1:0] instr_o,
    output logic [core_pkg::ADDR_SIZE-1:0] pc_o,
    output logic                           issue_o
);

    logic                           fetch_ok;
    logic                           redirect;
    logic [core_pkg::ADDR_SIZE-1:0] fetch_pc_q;

    assign lookup_o   = (stage_i == core_pkg::IF_STAGE);
    assign fetch_ok   = lookup_o && hit_i;
    assign redirect   = (stage_i == core_pkg::WB_STAGE) && tkbr_i;
    assign fetch_pc_o = fetch_pc_q;

    // Program counter
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fetch_pc_q <= '0;
        end else if (fetch_ok) begin
            fetch_pc_q <= fetch_pc_q + core_pkg::ADDR_SIZE'(core_pkg::WORD_BYTES);
        end else if (redirect) begin
            fetch_pc_q <= new_pc_i;
        end
    end

    // Word to decode, NOP when nothing was fetched
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            issue_o <= 1'b0;
            instr_o <= core_pkg::NOP_INSTR;
        end else begin
            issue_o <= fetch_ok;
            instr_o <= fetch_ok ? word_i : core_pkg::NOP_INSTR;
        end
    end

    // pc of the issued word
    always_ff @(posedge clk_i) begin
        if (fetch_ok) begin
            pc_o <= fetch_pc_q;
        end
    end

endmodule : if_stage

// ==== logic/icache.sv ====
`timescale 1ns/1ps

module icache #(
    parameter int NUM_LINES = 8
) (
    input  logic                           clk_i,
    input  logic                           rst_n_i,

    // Fetch side
    input  logic                           lookup_i,
    input  logic [core_pkg::ADDR_SIZE-1:0] addr_i,
    output logic                           hit_o,
    output logic [core_pkg::WORD_SIZE-1:0] word_o,

    // Memory side
    input  cache_pkg::line_t               mem_line_i,
    input  logic                           mem_ready_i,
    output cache_pkg::mem_req_t            mem_req_o
);

    localparam int OFFSET_W = cache_pkg::OFFSET_W;
    localparam int INDEX_W = $clog2(NUM_LINES);
    localparam int TAG_W = core_pkg::ADDR_SIZE - OFFSET_W - INDEX_W;
    localparam int WORD_LSB = $clog2(core_pkg::WORD_BYTES);
    localparam int WORD_SEL_W = cache_pkg::WORD_SEL_W;

    // Storage arrays
    logic [NUM_LINES-1:0]         valid_q;
    logic [TAG_W-1:0]             tag_q [NUM_LINES];
    cache_pkg::line_t             data_q [NUM_LINES];

    // Address fields of the lookup
    logic [INDEX_W-1:0]           index;
    logic [TAG_W-1:0]             tag;
    logic [WORD_SEL_W-1:0]        word_sel;

    // Fields of the line being refilled
    logic [INDEX_W-1:0]           fill_index;
    logic [TAG_W-1:0]             fill_tag;

    // Outstanding request
    logic                         rd_q;
    logic [core_pkg::ADDR_SIZE-1:0] line_addr_q;

    cache_pkg::line_t             sel_line;

    assign index    = addr_i[OFFSET_W +: INDEX_W];
    assign tag      = addr_i[core_pkg::ADDR_SIZE-1 -: TAG_W];
    assign word_sel = addr_i[WORD_LSB +: WORD_SEL_W];

    assign fill_index = line_addr_q[OFFSET_W +: INDEX_W];
    assign fill_tag   = line_addr_q[core_pkg::ADDR_SIZE-1 -: TAG_W];

    // Combinational hit on the registered fetch address
    assign hit_o = lookup_i && valid_q[index] && (tag_q[index] == tag);

    assign sel_line = data_q[index];
    assign word_o   = sel_line[word_sel * core_pkg::WORD_BYTES +: core_pkg::WORD_BYTES];

    assign mem_req_o.rd        = rd_q;
    assign mem_req_o.line_addr = line_addr_q;

    // Read level, held from the miss until the ready pulse
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_q <= 1'b0;
        end else if (mem_ready_i) begin
            rd_q <= 1'b0;
        end else if (lookup_i && !hit_o) begin
            rd_q <= 1'b1;
        end
    end

    // Line address captured only when a request starts
    always_ff @(posedge clk_i) begin
        if (!rd_q && !mem_ready_i && lookup_i && !hit_o) begin
            line_addr_q <= {addr_i[core_pkg::ADDR_SIZE-1:OFFSET_W], {OFFSET_W{1'b0}}};
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (mem_ready_i) begin
            valid_q[fill_index] <= 1'b1;
        end
    end

    // Refill replaces whatever sits at the index
    always_ff @(posedge clk_i) begin
        if (mem_ready_i) begin
            tag_q[fill_index]  <= fill_tag;
            data_q[fill_index] <= mem_line_i;
        end
    end

endmodule : icache

// ==== logic/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top #(
    parameter int NUM_LINES = 8
) (
    input  logic                           clk_i,
    input  logic                           rst_n_i,

    // Memory port
    input  cache_pkg::line_t               mem_line_i,
    input  logic                           mem_ready_i,
    output cache_pkg::mem_req_t            mem_req_o,

    // Branch outcome
    input  logic                           tkbr_i,
    input  logic [core_pkg::ADDR_SIZE-1:0] new_pc_i,

    // Decode side
    output logic [core_pkg::WORD_SIZE-1:0] instr_o,
    output logic [core_pkg::ADDR_SIZE-1:0] pc_o,
    output logic                           issue_o,
    output core_pkg::stage_e               stage_o
);

    core_pkg::stage_e               stage;
    logic                           hit;
    logic                           lookup;
    logic [core_pkg::WORD_SIZE-1:0] word;
    logic [core_pkg::ADDR_SIZE-1:0] fetch_pc;

    assign stage_o = stage;

    stage_ctrl u_stage_ctrl (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .hit_i   (hit),
        .stage_o (stage)
    );

    if_stage u_if_stage (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .stage_i    (stage),
        .hit_i      (hit),
        .word_i     (word),
        .lookup_o   (lookup),
        .fetch_pc_o (fetch_pc),
        .tkbr_i     (tkbr_i),
        .new_pc_i   (new_pc_i),
        .instr_o    (instr_o),
        .pc_o       (pc_o),
        .issue_o    (issue_o)
    );

    icache #(
        .NUM_LINES (NUM_LINES)
    ) u_icache (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .lookup_i    (lookup),
        .addr_i      (fetch_pc),
        .hit_o       (hit),
        .word_o      (word),
        .mem_line_i  (mem_line_i),
        .mem_ready_i (mem_ready_i),
        .mem_req_o   (mem_req_o)
    );

endmodule : fetch_top

// ==== sim/line_mem.sv ====
`timescale 1ns/1ps

module line_mem #(
    parameter logic [31:0] SEED = 32'h128f_98ac
) (
    input  logic                clk_i,
    input  cache_pkg::mem_req_t mem_req_i,
    output cache_pkg::line_t    mem_line_o,
    output logic                mem_ready_o
);

    integer                         seed;
    logic                           busy;
    logic [1:0]                     wait_cnt;
    logic [31:0]                    rnd;
    logic [core_pkg::ADDR_SIZE-1:0] req_addr;

    // Bit 31 is always set, so no word reads back as a NOP
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        logic [31:0] h;
        h = addr * 32'h9e37_79b1;
        h = h ^ {h[15:0], h[31:16]};
        return h | 32'h8000_0000;
    endfunction

    function automatic cache_pkg::line_t line_at(input logic [31:0] base);
        cache_pkg::line_t line;
        for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
            line[w*4 +: 4] = word_at(base + 32'(w * 4));
        end
        return line;
    endfunction

    initial begin
        seed        = SEED;
        busy        = 1'b0;
        wait_cnt    = 2'd0;
        rnd         = '0;
        req_addr    = '0;
        mem_line_o  = '0;
        mem_ready_o = 1'b0;
        forever begin
            @(posedge clk_i);
            #1;
            if (mem_ready_o) begin
                // Cache took the line at this edge, rd is low again
                mem_ready_o = 1'b0;
            end else if (busy) begin
                if (wait_cnt == 2'd0) begin
                    mem_line_o  = line_at(req_addr);
                    mem_ready_o = 1'b1;
                    busy        = 1'b0;
                end else begin
                    wait_cnt = wait_cnt - 2'd1;
                end
            end else if (mem_req_i.rd) begin
                // Latency of 1 to 4 cycles
                rnd      = $random(seed);
                wait_cnt = rnd[1:0];
                req_addr = mem_req_i.line_addr;
                busy     = 1'b1;
            end
        end
    end

endmodule : line_mem

// ==== sim/fetch_props.sv ====
`timescale 1ns/1ps

module fetch_props (
    input logic                clk_i,
    input logic                rst_n_i,
    input cache_pkg::mem_req_t mem_req_i,
    input core_pkg::stage_e    stage_i
);

    // Request address held for the whole read
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_i.rd |=> (!mem_req_i.rd || $stable(mem_req_i.line_addr)))
        else $error("line_addr changed while rd was high");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stage_i == core_pkg::IF_STAGE |=>
            (stage_i == core_pkg::IF_STAGE || stage_i == core_pkg::ID_STAGE))
        else $error("stage after IF is neither IF nor ID");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stage_i == core_pkg::ID_STAGE |=> stage_i == core_pkg::EX_STAGE)
        else $error("stage after ID is not EX");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stage_i == core_pkg::EX_STAGE |=> stage_i == core_pkg::WB_STAGE)
        else $error("stage after EX is not WB");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stage_i == core_pkg::WB_STAGE |=> stage_i == core_pkg::IF_STAGE)
        else $error("stage after WB is not IF");

endmodule : fetch_props

bind fetch_top fetch_props u_fetch_props (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .mem_req_i (mem_req_o),
    .stage_i   (stage_o)
);

// ==== sim/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;

    localparam int          NUM_LINES   = 8;
    localparam int          INDEX_W     = $clog2(NUM_LINES);
    localparam int          NUM_ISSUES  = 300;
    localparam int          CYCLE_LIMIT = NUM_ISSUES * (4 + 5) + 200;
    localparam logic [31:0] SEED        = 32'h128f_98ac;

    logic                           clk;
    logic                           rst_n;
    cache_pkg::line_t               mem_line;
    logic                           mem_ready;
    cache_pkg::mem_req_t            mem_req;
    logic                           tkbr;
    logic [core_pkg::ADDR_SIZE-1:0] new_pc;
    logic [core_pkg::WORD_SIZE-1:0] instr;
    logic [core_pkg::ADDR_SIZE-1:0] pc;
    logic                           issue;
    core_pkg::stage_e               stage;

    // Reference model
    integer                         seed;
    logic [31:0]                    rnd;
    logic [31:0]                    exp_pc;
    logic                           exp_issue;
    core_pkg::stage_e               exp_stage;
    logic [NUM_LINES-1:0]           model_valid;
    logic [27:0]                    model_line [NUM_LINES];
    logic [31:0]                    req_line;
    logic                           prev_rd;
    logic                           branch_pending;
    logic [31:0]                    branch_pc;
    int                             cycles;
    int                             issued;

    fetch_top #(
        .NUM_LINES (NUM_LINES)
    ) UUT (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .mem_line_i  (mem_line),
        .mem_ready_i (mem_ready),
        .mem_req_o   (mem_req),
        .tkbr_i      (tkbr),
        .new_pc_i    (new_pc),
        .instr_o     (instr),
        .pc_o        (pc),
        .issue_o     (issue),
        .stage_o     (stage)
    );

    line_mem #(
        .SEED (SEED)
    ) u_line_mem (
        .clk_i       (clk),
        .mem_req_i   (mem_req),
        .mem_line_o  (mem_line),
        .mem_ready_o (mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("** Error: time %0t: %s is %h, expected %h", $time, name, got, exp);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("Error at time %0t: %s", $time, what);
        $display("TB FAILED");
        $fatal(1);
    endtask

    // Memory content rule, bit 31 forced so it never matches a NOP
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] h;
        h = addr * 32'h9e37_79b1;
        h = h ^ {h[15:0], h[31:16]};
        return h | 32'h8000_0000;
    endfunction

    function automatic logic model_holds(input logic [31:0] addr);
        logic [INDEX_W-1:0] idx;
        idx = addr[4 +: INDEX_W];
        return model_valid[idx] && (model_line[idx] == addr[31:4]);
    endfunction

    function automatic core_pkg::stage_e next_stage(input core_pkg::stage_e cur,
                                                    input logic took);
        case (cur)
            core_pkg::IF_STAGE: return took ? core_pkg::ID_STAGE : core_pkg::IF_STAGE;
            core_pkg::ID_STAGE: return core_pkg::EX_STAGE;
            core_pkg::EX_STAGE: return core_pkg::WB_STAGE;
            default:            return core_pkg::IF_STAGE;
        endcase
    endfunction

    initial begin
        seed           = SEED;
        rst_n          = 1'b0;
        tkbr           = 1'b0;
        new_pc         = '0;
        rnd            = '0;
        exp_pc         = '0;
        exp_issue      = 1'b0;
        exp_stage      = core_pkg::IF_STAGE;
        model_valid    = '0;
        req_line       = '0;
        prev_rd        = 1'b0;
        branch_pending = 1'b0;
        branch_pc      = '0;
        cycles         = 0;
        issued         = 0;
        for (int i = 0; i < NUM_LINES; i++) begin
            model_line[i] = '0;
        end

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Out of reset, nothing requested or issued yet
        assert (mem_req.rd == 1'b0)
            else report_mismatch("mem_req_o.rd", {31'd0, mem_req.rd}, 32'd0);
        assert (issue == 1'b0)
            else report_mismatch("issue_o", {31'd0, issue}, 32'd0);
        assert (stage == core_pkg::IF_STAGE)
            else report_mismatch("stage_o", {30'd0, stage}, 32'd0);
        assert (instr == core_pkg::NOP_INSTR)
            else report_mismatch("instr_o", instr, core_pkg::NOP_INSTR);

        while (issued < NUM_ISSUES) begin
            @(posedge clk);
            #1;
            cycles++;
            assert (cycles <= CYCLE_LIMIT)
                else report_failure("run timed out before all instructions were issued");

            // A held line hits in IF and issues at this edge
            exp_issue = (exp_stage == core_pkg::IF_STAGE) && model_holds(exp_pc);

            // Redirect taken at the WB edge
            if (branch_pending) begin
                exp_pc         = branch_pc;
                branch_pending = 1'b0;
            end

            exp_stage = next_stage(exp_stage, exp_issue);
            assert (stage == exp_stage)
                else report_mismatch("stage_o", {30'd0, stage}, {30'd0, exp_stage});
            assert (issue == exp_issue)
                else report_mismatch("issue_o", {31'd0, issue}, {31'd0, exp_issue});

            if (exp_issue) begin
                assert (pc == exp_pc)
                    else report_mismatch("pc_o", pc, exp_pc);
                assert (instr == expected_word(exp_pc))
                    else report_mismatch("instr_o", instr, expected_word(exp_pc));
                exp_pc = exp_pc + 32'd4;
                issued++;
            end else begin
                assert (instr == core_pkg::NOP_INSTR)
                    else report_mismatch("instr_o", instr, core_pkg::NOP_INSTR);
            end

            // Refill request opens on rd rising, line is installed as rd falls
            if (mem_req.rd && !prev_rd) begin
                assert (!model_holds(exp_pc))
                    else report_failure("read requested for a line the cache already holds");
                assert (mem_req.line_addr == {exp_pc[31:4], 4'h0})
                    else report_mismatch("mem_req_o.line_addr", mem_req.line_addr,
                                         {exp_pc[31:4], 4'h0});
                req_line = mem_req.line_addr;
            end else if (!mem_req.rd && prev_rd) begin
                model_valid[req_line[4 +: INDEX_W]] = 1'b1;
                model_line[req_line[4 +: INDEX_W]]  = req_line[31:4];
            end
            prev_rd = mem_req.rd;

            // Branch inputs are noise outside WB
            rnd = $random(seed);
            if (exp_stage == core_pkg::WB_STAGE) begin
                tkbr           = (rnd[1:0] == 2'd0);
                new_pc         = {23'd0, rnd[10:4], 2'b00};
                branch_pending = tkbr;
                branch_pc      = new_pc;
            end else begin
                tkbr   = rnd[0];
                new_pc = rnd;
            end
        end

        $display("TB PASSED");
        $finish;
    end

endmodule : fetch_tb

// ==== all.f ====
logic/core_pkg.sv
logic/cache_pkg.sv
logic/stage_ctrl.sv
logic/if_stage.sv
logic/icache.sv
logic/fetch_top.sv
sim/line_mem.sv
sim/fetch_props.sv
sim/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module fetch_tb -f all.f -o fetch_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fetch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

exit 0
